/* verilog.f */
sandboxPkg.sv
hostSequencer.sv
trialEngine.sv
activityIndicator.sv
sandboxTop.sv
tbMemoryModel.sv
sandboxTb.sv

/* runSim.sh */
#!/bin/sh
# build the sandbox testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module sandboxTb -o simSandbox \
  > build.log 2>&1 \
  && ./obj_dir/simSandbox > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -qF "Checks failed" sim.log && exit 1 || exit 0

/* sandboxTb.sv */
// ------------------------------
// testbench for the sandbox, host requests against a modelled memory
// handshake and LED checks run on every request
// ------------------------------
module sandboxTb;
  import sandboxPkg::*;

  localparam int CLOCK_PERIOD   = 20;
  localparam int SLOW_PERIOD    = 160;
  localparam int TRIAL_CYCLES   = 2 * MEM_WORDS + 3;
  localparam int REQUEST_CYCLES = 40;   // handshake plus LED pulse
  localparam int REQUEST_BUDGET = 16;
  localparam int WATCHDOG_TIME  =
    (2 * TRIAL_CYCLES + REQUEST_BUDGET * REQUEST_CYCLES + 100) * CLOCK_PERIOD;

  logic masterClock, reset, slowClock, dataReceived, transmitData, clearDR, rxIndicator;
  logic [7:0]                 control, status;
  logic [31:0]                inputData, outputData;
  logic [MEM_ADDR_WIDTH-1:0]  memAddress;
  logic                       memWrite, memRead, faultEnable;
  logic [MEM_DATA_WIDTH-1:0]  memWriteData, memReadData;
  logic [MEM_INDEX_WIDTH-1:0] faultIndex;
  logic [31:0]                lfsrState = 32'hd4af_24a9;
  int errorCount = 0, checkCount = 0, testCount = 0, testErrors = 0;
  int requestCount = 0, pulsesSeen = 0;

  sandboxTop i_sandboxTop (.*);

  tbMemoryModel i_tbMemoryModel (
    .masterClock(masterClock), .address(memAddress), .writeEnable(memWrite),
    .readEnable(memRead), .writeData(memWriteData), .readData(memReadData),
    .faultEnable(faultEnable), .faultIndex(faultIndex)
  );

  initial
  begin
    masterClock = 1'b0;
    forever #(CLOCK_PERIOD / 2) masterClock = ~masterClock;
  end

  initial
  begin
    slowClock = 1'b0;     // edges fall between masterClock rising edges
    forever #(SLOW_PERIOD / 2) slowClock = ~slowClock;
  end

  always @(posedge rxIndicator) pulsesSeen++;

  function automatic void reportFailure(string what);
    $display("Error at %0t: %s", $time, what);
    errorCount++;
  endfunction

  function automatic void checkValue(string name, logic [31:0] got, logic [31:0] expected);
    checkCount++;
    assert (got === expected)
    else
    begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
      errorCount++;
    end
  endfunction

  // galois step per bit taken
  function automatic logic [31:0] takeBits(int count);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < count; i++)
    begin
      bits[i]   = lfsrState[0];
      lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'ha300_0000 : 32'h0);
    end
    return bits;
  endfunction

  function automatic logic [31:0] statusByte(logic flag, logic result);
    logic [31:0] value;
    value                    = '0;
    value[STATUS_FLAG_BIT]   = flag;
    value[STATUS_RESULT_BIT] = result;
    return value;
  endfunction

  // ------------------------------
  // handshake timing, edge N is acceptance
  // ------------------------------
  assert property (@(posedge masterClock) disable iff (!reset)
    $past(dataReceived, 2) && !$past(dataReceived, 3) |-> transmitData && !$past(transmitData))
  else reportFailure("transmitData did not rise one cycle after acceptance");

  assert property (@(posedge masterClock) disable iff (!reset)
    $past(dataReceived, 4) && !$past(dataReceived, 5) |-> clearDR && !$past(clearDR))
  else reportFailure("clearDR did not rise three cycles after acceptance");

  assert property (@(posedge masterClock) disable iff (!reset)
    $past(dataReceived, 2) && !$past(dataReceived)
      |-> !transmitData && !clearDR && $past(transmitData) && $past(clearDR))
  else reportFailure("transmitData and clearDR did not fall together after release");

  assert property (@(posedge masterClock) disable iff (!reset) transmitData |-> $stable(status))
  else reportFailure("status changed while transmitData was high");

  task automatic applyReset();
    @(posedge masterClock);
    reset <= 1'b0;
    repeat (4) @(posedge masterClock);
    reset <= 1'b1;
    @(posedge masterClock);
  endtask

  task automatic finishTest(string name);
    testCount++;
    $display("test %-16s %s", name, (errorCount == testErrors) ? "pass" : "FAIL");
    testErrors = errorCount;
  endtask

  // one LED pulse per request, a slow period wide
  task automatic checkIndicatorPulse();
    int waited;
    int width;
    waited = 0;
    width  = 0;
    while (!rxIndicator && waited < 60)
    begin
      @(posedge masterClock);
      waited++;
    end
    if (!rxIndicator)
      reportFailure("rxIndicator did not pulse after a request");
    while (rxIndicator && width < 20)
    begin
      width++;
      @(posedge masterClock);
    end
    checkValue("rxIndicator width", 32'(width), 32'(SLOW_PERIOD / CLOCK_PERIOD));
    checkValue("rxIndicator pulses", 32'(pulsesSeen), 32'(requestCount));
  endtask

  task automatic sendRequest(input hostCommand cmd, output logic [7:0] gotStatus,
                             output logic [31:0] gotData);
    int waited;
    waited = 0;
    checkValue("rxIndicator pulses", 32'(pulsesSeen), 32'(requestCount));
    @(posedge masterClock);
    control      <= {7'b0, cmd};
    inputData    <= takeBits(32);   // ignored by both commands
    dataReceived <= 1'b1;
    requestCount++;
    @(posedge masterClock);
    while (!transmitData && waited < 10)
    begin
      @(posedge masterClock);
      waited++;
    end
    gotStatus = status;
    gotData   = outputData;
    while (!clearDR && waited < 10)
    begin
      @(posedge masterClock);
      waited++;
    end
    if (!clearDR)
      reportFailure("host handshake did not reach clearDR");
    dataReceived <= 1'b0;
    checkIndicatorPulse();
  endtask

  // query until the flag says the trial has run
  task automatic waitForTrialEnd(output logic [7:0] gotStatus, output logic [31:0] gotData);
    int polls;
    polls     = 0;
    gotStatus = '0;
    while (!gotStatus[STATUS_FLAG_BIT] && polls < 12)
    begin
      sendRequest(cmdQuery, gotStatus, gotData);
      polls++;
    end
    if (!gotStatus[STATUS_FLAG_BIT])
      reportFailure("trial did not finish within the poll limit");
  endtask

  initial
  begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired at %0t, the run did not finish", $time);
    $display("Checks failed");
    $finish;
  end

  initial
  begin
    logic [7:0]                 gotStatus;
    logic [31:0]                gotData;
    logic [31:0]                keptData;
    logic [MEM_INDEX_WIDTH-1:0] faultWord;
    reset        = 1'b0;
    dataReceived = 1'b0;
    control      = '0;
    inputData    = '0;
    faultEnable  = 1'b0;
    faultIndex   = '0;

    // ------------------------------
    applyReset();
    checkValue("transmitData", 32'(transmitData), 32'h0);
    checkValue("clearDR", 32'(clearDR), 32'h0);
    checkValue("rxIndicator", 32'(rxIndicator), 32'h0);
    checkValue("status", 32'(status), 32'h0);
    checkValue("outputData", outputData, 32'h0);
    sendRequest(cmdQuery, gotStatus, gotData);
    checkValue("status", 32'(gotStatus), statusByte(1'b0, 1'b0));
    checkValue("outputData", gotData, 32'h0);
    finishTest("reset state");

    keptData = outputData;
    sendRequest(cmdStart, gotStatus, gotData);
    checkValue("status", 32'(gotStatus), statusByte(1'b1, 1'b0));
    sendRequest(cmdStart, gotStatus, gotData);   // trial still busy
    checkValue("status", 32'(gotStatus), statusByte(1'b0, 1'b0));
    waitForTrialEnd(gotStatus, gotData);
    checkValue("status", 32'(gotStatus), statusByte(1'b1, 1'b1));
    checkValue("outputData", gotData, keptData);
    finishTest("good run");

    sendRequest(cmdStart, gotStatus, gotData);
    checkValue("status", 32'(gotStatus), statusByte(1'b0, 1'b1));
    checkValue("outputData", gotData, keptData);
    finishTest("refused restart");

    // ------------------------------
    faultWord = MEM_INDEX_WIDTH'(takeBits(MEM_INDEX_WIDTH));
    @(posedge masterClock);
    faultIndex  <= faultWord;
    faultEnable <= 1'b1;
    applyReset();
    sendRequest(cmdStart, gotStatus, gotData);
    checkValue("status", 32'(gotStatus), statusByte(1'b1, 1'b0));
    waitForTrialEnd(gotStatus, gotData);
    checkValue("status", 32'(gotStatus), statusByte(1'b1, 1'b0));
    checkValue("outputData", gotData, 32'(faultWord));
    finishTest("faulty memory");

    $display("tests %0d, requests %0d, checks %0d, errors %0d",
             testCount, requestCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

/* tbMemoryModel.sv */
// ------------------------------
// testbench memory of 64-bit words with one-cycle read latency
// faultEnable flips bit 0 of the word at faultIndex on reads
// ------------------------------
module tbMemoryModel (
  input  logic                                   masterClock,
  input  logic [sandboxPkg::MEM_ADDR_WIDTH-1:0]  address,      // byte address
  input  logic                                   writeEnable,
  input  logic                                   readEnable,
  input  logic [sandboxPkg::MEM_DATA_WIDTH-1:0]  writeData,
  output logic [sandboxPkg::MEM_DATA_WIDTH-1:0]  readData,
  input  logic                                   faultEnable,
  input  logic [sandboxPkg::MEM_INDEX_WIDTH-1:0] faultIndex
);
  import sandboxPkg::*;

  logic [MEM_DATA_WIDTH-1:0]  words [MEM_WORDS];
  logic [MEM_INDEX_WIDTH-1:0] wordIndex;

  assign wordIndex = address[MEM_ADDR_WIDTH-1 -: MEM_INDEX_WIDTH];  // low 3 bits pick a byte

  // power-up fill from the word index, never equal to an expected word
  initial
  begin
    readData <= '0;
    for (int i = 0; i < MEM_WORDS; i++)
      words[i] <= {2{~32'(i)}};
  end

  always @(posedge masterClock)
  begin
    if (writeEnable)
      words[wordIndex] <= writeData;
    if (readEnable)
    begin
      if (faultEnable && wordIndex == faultIndex)
        readData <= words[wordIndex] ^ 64'h1;   // stuck bit 0
      else
        readData <= words[wordIndex];
    end
  end

endmodule

/* sandboxTop.sv */
// ------------------------------
// memory-test sandbox, host register port plus external memory port
// ------------------------------
module sandboxTop (
  input  logic                                  masterClock,
  input  logic                                  reset,         // sync, active low
  input  logic                                  slowClock,     // LED pacing, sampled only
  input  logic                                  dataReceived,
  input  logic [7:0]                            control,
  input  logic [31:0]                           inputData,     // no command takes a data word
  output logic                                  transmitData,
  output logic                                  clearDR,
  output logic [7:0]                            status,
  output logic [31:0]                           outputData,
  output logic                                  rxIndicator,
  output logic [sandboxPkg::MEM_ADDR_WIDTH-1:0] memAddress,
  output logic                                  memWrite,
  output logic                                  memRead,
  output logic [sandboxPkg::MEM_DATA_WIDTH-1:0] memWriteData,
  input  logic [sandboxPkg::MEM_DATA_WIDTH-1:0] memReadData
);
  import sandboxPkg::*;

  logic                       runStrobe;
  logic                       isRunning;
  logic                       didRun;
  logic                       wasSuccessful;
  logic [MEM_INDEX_WIDTH-1:0] failIndex;
  logic                       indicatorTrigger;

  hostSequencer i_hostSequencer (
    .masterClock(masterClock), .reset(reset),
    .dataReceived(dataReceived), .control(control),
    .isRunning(isRunning), .didRun(didRun),
    .wasSuccessful(wasSuccessful), .failIndex(failIndex),
    .transmitData(transmitData), .clearDR(clearDR),
    .status(status), .outputData(outputData),
    .runStrobe(runStrobe), .indicatorTrigger(indicatorTrigger)
  );

  trialEngine i_trialEngine (
    .masterClock(masterClock), .reset(reset), .runStrobe(runStrobe),
    .isRunning(isRunning), .didRun(didRun),
    .wasSuccessful(wasSuccessful), .failIndex(failIndex),
    .memAddress(memAddress), .memWrite(memWrite), .memRead(memRead),
    .memWriteData(memWriteData), .memReadData(memReadData)
  );

  activityIndicator i_activityIndicator (
    .masterClock(masterClock), .reset(reset), .slowClock(slowClock),
    .indicatorTrigger(indicatorTrigger), .rxIndicator(rxIndicator)
  );

endmodule

/* activityIndicator.sv */
// ------------------------------
// LED pulse of one slowClock period per accepted request
// slowClock is sampled on masterClock, never used as a clock
// ------------------------------
module activityIndicator (
  input  logic masterClock,
  input  logic reset,             // sync, active low
  input  logic slowClock,         // asynchronous to masterClock
  input  logic indicatorTrigger,  // one cycle per request
  output logic rxIndicator
);
  import sandboxPkg::*;

  indicatorState state;
  logic          slowMeta;        // first sync stage
  logic          slowSync;        // second sync stage
  logic          slowPrev;        // edge detect
  logic          slowRise;
  logic          slowFall;

  assign slowRise = slowSync && !slowPrev;
  assign slowFall = !slowSync && slowPrev;

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      slowMeta    <= 1'b0;
      slowSync    <= 1'b0;
      slowPrev    <= 1'b0;
      state       <= isIdle;
      rxIndicator <= 1'b0;
    end
    else
    begin
      slowMeta <= slowClock;
      slowSync <= slowMeta;
      slowPrev <= slowSync;

      case (state)
        isIdle :
        begin
          if (indicatorTrigger)   // ignored while a pulse runs
          begin
            state <= isWaitHigh1;
          end
        end

        isWaitHigh1 :
        begin
          if (slowRise)
          begin
            state <= isWaitLow1;
          end
        end

        isWaitLow1 :
        begin
          if (slowFall)
          begin
            state <= isWaitHigh2;
          end
        end

        isWaitHigh2 :
        begin
          if (slowRise)
          begin
            state <= isWaitLow2;
          end
        end

        isWaitLow2 :
        begin
          if (slowFall)
          begin
            if (!rxIndicator)
            begin
              rxIndicator <= 1'b1;  // second fall, pulse on
              state       <= isWaitHigh2;
            end
            else
            begin
              rxIndicator <= 1'b0;  // one period later, off
              state       <= isIdle;
            end
          end
        end

        default :
        begin
          state       <= isIdle;
          rxIndicator <= 1'b0;
        end
      endcase
    end
  end

endmodule

/* trialEngine.sv */
// ------------------------------
// single write-then-verify pass over the external memory
// start with runStrobe, verdict valid once didRun is high
// ------------------------------
module trialEngine (
  input  logic                                   masterClock,
  input  logic                                   reset,          // sync, active low
  input  logic                                   runStrobe,
  output logic                                   isRunning,
  output logic                                   didRun,         // sticky until reset
  output logic                                   wasSuccessful,
  output logic [sandboxPkg::MEM_INDEX_WIDTH-1:0] failIndex,      // first mismatch
  output logic [sandboxPkg::MEM_ADDR_WIDTH-1:0]  memAddress,     // byte address
  output logic                                   memWrite,
  output logic                                   memRead,
  output logic [sandboxPkg::MEM_DATA_WIDTH-1:0]  memWriteData,
  input  logic [sandboxPkg::MEM_DATA_WIDTH-1:0]  memReadData     // one cycle after memRead
);
  import sandboxPkg::*;

  trialState                  state;
  logic [MEM_INDEX_WIDTH-1:0] wordIndex;      // issue pointer
  logic                       compareValid;   // memReadData holds a word this cycle
  logic [MEM_INDEX_WIDTH-1:0] compareIndex;   // index of that word
  logic                       lastWord;
  logic                       mismatch;

  // pattern xor index, index copied into both halves
  function automatic logic [MEM_DATA_WIDTH-1:0] expectedWord(
    input logic [MEM_INDEX_WIDTH-1:0] index
  );
    logic [MEM_DATA_WIDTH/2-1:0] half;
    half = {{(MEM_DATA_WIDTH/2 - MEM_INDEX_WIDTH){1'b0}}, index};
    return TEST_PATTERN ^ {half, half};
  endfunction

  assign lastWord = (wordIndex == MEM_INDEX_WIDTH'(MEM_WORDS - 1));
  assign mismatch = compareValid && (memReadData != expectedWord(compareIndex));

  // ------------------------------
  // control FSM and verdict
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state         <= tsIdle;
      wordIndex     <= '0;
      memWrite      <= 1'b0;
      memRead       <= 1'b0;
      compareValid  <= 1'b0;
      isRunning     <= 1'b0;
      didRun        <= 1'b0;
      wasSuccessful <= 1'b0;
      failIndex     <= '0;
    end
    else
    begin
      memWrite     <= 1'b0;
      memRead      <= 1'b0;
      compareValid <= memRead;        // data lands one cycle after the read

      if (mismatch && wasSuccessful)  // keep only the first failure
      begin
        wasSuccessful <= 1'b0;
        failIndex     <= compareIndex;
      end

      case (state)
        tsIdle :
        begin
          if (runStrobe)
          begin
            isRunning     <= 1'b1;
            wasSuccessful <= 1'b1;    // pass until proven otherwise
            wordIndex     <= '0;
            state         <= tsWrite;
          end
        end

        tsWrite :
        begin
          memWrite <= 1'b1;
          if (lastWord)
          begin
            wordIndex <= '0;
            state     <= tsRead;
          end
          else
          begin
            wordIndex <= wordIndex + 1'b1;
          end
        end

        tsRead :
        begin
          memRead <= 1'b1;            // one read per cycle, no stalls
          if (lastWord)
          begin
            wordIndex <= '0;
            state     <= tsCompare;
          end
          else
          begin
            wordIndex <= wordIndex + 1'b1;
          end
        end

        tsCompare :
        begin
          // last word compared this edge
          if (compareValid && compareIndex == MEM_INDEX_WIDTH'(MEM_WORDS - 1))
          begin
            isRunning <= 1'b0;
            didRun    <= 1'b1;
            state     <= tsDone;
          end
        end

        tsDone :
        begin
          // no restart without reset
        end

        default :
        begin
          state <= tsIdle;
        end
      endcase
    end
  end

  // ------------------------------
  // address and data path
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (state == tsWrite || state == tsRead)
    begin
      memAddress <= {wordIndex, {(MEM_ADDR_WIDTH - MEM_INDEX_WIDTH){1'b0}}};
    end
    if (state == tsWrite)
    begin
      memWriteData <= expectedWord(wordIndex);
    end
    if (memRead)
    begin
      compareIndex <= memAddress[MEM_ADDR_WIDTH-1 -: MEM_INDEX_WIDTH];  // word of pending read
    end
  end

endmodule

/* hostSequencer.sv */
// ------------------------------
// host request decoder, starts trials and reports verdicts
// runs the transmit/clear handshake towards the host port
// ------------------------------
module hostSequencer (
  input  logic                                   masterClock,
  input  logic                                   reset,            // sync, active low
  input  logic                                   dataReceived,     // host request level
  input  logic [7:0]                             control,          // bit 0 selects command
  input  logic                                   isRunning,
  input  logic                                   didRun,
  input  logic                                   wasSuccessful,
  input  logic [sandboxPkg::MEM_INDEX_WIDTH-1:0] failIndex,
  output logic                                   transmitData,
  output logic                                   clearDR,
  output logic [7:0]                             status,
  output logic [31:0]                            outputData,
  output logic                                   runStrobe,        // one cycle, to engine
  output logic                                   indicatorTrigger  // one cycle, to LED
);
  import sandboxPkg::*;

  hostState   state;
  hostCommand command;

  assign command = hostCommand'(control[0]);  // upper control bits ignored

  // ------------------------------
  // request FSM
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state            <= hsIdle;
      transmitData     <= 1'b0;
      clearDR          <= 1'b0;
      status           <= '0;
      outputData       <= '0;
      runStrobe        <= 1'b0;
      indicatorTrigger <= 1'b0;
    end
    else
    begin
      runStrobe        <= 1'b0;   // strobes by default low
      indicatorTrigger <= 1'b0;

      case (state)
        hsIdle :
        begin
          if (dataReceived)
          begin
            indicatorTrigger <= 1'b1;     // every request blinks
            status           <= '0;       // bits set below win
            state            <= hsAnswer;

            if (command == cmdStart)
            begin
              if (isRunning)
              begin
                // busy, answer 00
              end
              else if (didRun)
              begin
                status[STATUS_RESULT_BIT] <= 1'b1;  // refused, one trial per reset
              end
              else
              begin
                status[STATUS_FLAG_BIT] <= 1'b1;    // accepted
                runStrobe               <= 1'b1;
              end
            end
            else
            begin
              status[STATUS_FLAG_BIT] <= didRun;
              if (didRun)
              begin
                status[STATUS_RESULT_BIT] <= wasSuccessful;
                if (!wasSuccessful)
                begin
                  outputData <= {{(32 - MEM_INDEX_WIDTH){1'b0}}, failIndex};
                end
              end
            end
          end
        end

        hsAnswer :
        begin
          transmitData <= 1'b1;   // answer ready for host
          state        <= hsHold;
        end

        hsHold :
        begin
          state <= hsClear;
        end

        hsClear :
        begin
          clearDR <= 1'b1;        // ready for next request
          state   <= hsWaitRelease;
        end

        hsWaitRelease :
        begin
          if (!dataReceived)
          begin
            transmitData <= 1'b0; // both drop together
            clearDR      <= 1'b0;
            state        <= hsIdle;
          end
        end

        default :
        begin
          state <= hsIdle;
        end
      endcase
    end
  end

endmodule

/* sandboxPkg.sv */
// ------------------------------
// shared geometry, pattern, status bit positions and FSM encodings
// import inside module bodies, scoped names in port lists
// ------------------------------
package sandboxPkg;

  // ------------------------------
  // memory under test
  // ------------------------------
  localparam int MEM_WORDS       = 64;   // words per trial
  localparam int MEM_INDEX_WIDTH = 6;    // word index bits
  localparam int MEM_ADDR_WIDTH  = 9;    // byte address = index * 8
  localparam int MEM_DATA_WIDTH  = 64;   // one memory word

  // expected word = pattern ^ {index, index}, zero-extended halves
  localparam logic [MEM_DATA_WIDTH-1:0] TEST_PATTERN = 64'h5a3c_c3a5_96e1_1e69;

  // ------------------------------
  // status byte layout
  // ------------------------------
  localparam int STATUS_FLAG_BIT   = 0;  // started / has run
  localparam int STATUS_RESULT_BIT = 1;  // refused / passed

  // host command, from control bit 0
  typedef enum logic {
    cmdQuery = 1'b0,
    cmdStart = 1'b1
  } hostCommand;

  typedef enum logic [2:0] {
    hsIdle,             // waiting for dataReceived
    hsAnswer,           // status valid, raise transmitData
    hsHold,             // one spare cycle
    hsClear,            // raise clearDR
    hsWaitRelease       // wait for host to drop dataReceived
  } hostState;

  typedef enum logic [2:0] {
    tsIdle,             // waiting for runStrobe
    tsWrite,            // write pass
    tsRead,             // read issue pass
    tsCompare,          // drain read pipeline
    tsDone              // verdict held until reset
  } trialState;

  typedef enum logic [2:0] {
    isIdle,
    isWaitHigh1,        // first slow rising edge
    isWaitLow1,         // first slow falling edge
    isWaitHigh2,        // next rising edge
    isWaitLow2          // falling edge, toggles the pulse
  } indicatorState;

endpackage
